//--- src/mips_pkg.sv
package mips_pkg;

    // request from one bus master, held until waitrequest is low.
    typedef struct packed {
        logic [31:0] address;
        logic        read;
        logic        write;
        logic [31:0] writedata;
    } bus_req_t;

    typedef struct packed {
        logic        waitrequest; // high while the transfer is not yet done.
        logic [31:0] readdata;
    } bus_rsp_t;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_type_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_type_t;

    // one instruction word, seen either as R-type or as I-type.
    typedef union packed {
        r_type_t r_view;
        i_type_t i_view;
    } instr_t;

    typedef enum logic [2:0] {IDLE, FETCH, EXEC, MEM, WB, HALT} core_state_t;

    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_sw      = 6'h2B;

    localparam logic [5:0] fn_sllv = 6'h04;
    localparam logic [5:0] fn_srlv = 6'h06;
    localparam logic [5:0] fn_srav = 6'h07;
    localparam logic [5:0] fn_jr   = 6'h08;
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;

endpackage

//--- src/bus_arbiter.sv
`timescale 1ns/100ps

module bus_arbiter import mips_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  bus_req_t lsu_req,
    output bus_rsp_t lsu_rsp,
    input  bus_req_t ifu_req,
    output bus_rsp_t ifu_rsp,
    output bus_req_t mem_req,
    input  bus_rsp_t mem_rsp
);

    logic lsu_strobe;
    logic ifu_strobe;
    logic mem_strobe;
    logic grant_ifu;
    logic locked;
    logic owner_ifu_q;

    assign lsu_strobe = lsu_req.read | lsu_req.write;
    assign ifu_strobe = ifu_req.read | ifu_req.write;
    assign mem_strobe = mem_req.read | mem_req.write;

    // load/store wins a tie; a transfer in progress keeps its owner.
    assign grant_ifu = locked ? owner_ifu_q : (!lsu_strobe && ifu_strobe);

    always_comb begin
        mem_req             = grant_ifu ? ifu_req : lsu_req;
        lsu_rsp.readdata    = mem_rsp.readdata;
        ifu_rsp.readdata    = mem_rsp.readdata;
        lsu_rsp.waitrequest = grant_ifu ? 1'b1 : mem_rsp.waitrequest;
        ifu_rsp.waitrequest = grant_ifu ? mem_rsp.waitrequest : 1'b1;
    end

    // the lock is taken while the RAM stalls and dropped on the completing edge.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            locked      <= 1'b0;
            owner_ifu_q <= 1'b0;
        end else if (mem_strobe && mem_rsp.waitrequest) begin
            locked      <= 1'b1;
            owner_ifu_q <= grant_ifu;
        end else begin
            locked <= 1'b0;
        end
    end

endmodule

//--- src/instr_fetch.sv
`timescale 1ns/100ps

module instr_fetch import mips_pkg::*; #(
    parameter logic [31:0] RESET_PC = 32'd4
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        start_fetch,
    input  logic        pc_load,
    input  logic [31:0] new_pc,
    output logic        fetch_done,
    output instr_t      instr,
    output logic [31:0] pc,
    output bus_req_t    bus_req,
    input  bus_rsp_t    bus_rsp
);

    logic   busy;
    logic   done_q;
    instr_t instr_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy   <= 1'b0;
            done_q <= 1'b0;
            pc     <= RESET_PC;
        end else begin
            done_q <= 1'b0;
            if (start_fetch) begin
                busy <= 1'b1;
            end else if (busy && !bus_rsp.waitrequest) begin
                busy   <= 1'b0;
                done_q <= 1'b1;
                pc     <= pc + 32'd4;
            end
            if (pc_load) pc <= new_pc; // a jump target replaces the sequential pc.
        end
    end

    // the RAM registers readdata on completion, so it is valid while done_q is high.
    always_ff @(posedge clk) begin
        if (done_q) instr_q <= instr_t'(bus_rsp.readdata);
    end

    assign fetch_done = done_q;
    assign instr      = done_q ? instr_t'(bus_rsp.readdata) : instr_q;

    always_comb begin
        bus_req.address   = pc;
        bus_req.read      = busy;
        bus_req.write     = 1'b0;
        bus_req.writedata = '0;
    end

endmodule

//--- src/load_store_unit.sv
`timescale 1ns/100ps

module load_store_unit import mips_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        mem_start,
    input  logic        mem_write,
    input  logic [31:0] mem_addr,
    input  logic [31:0] store_data,
    output logic        mem_done,
    output logic [31:0] load_data,
    output bus_req_t    bus_req,
    input  bus_rsp_t    bus_rsp
);

    logic        busy;
    logic        done_q;
    logic        write_q;
    logic [31:0] addr_q;
    logic [31:0] data_q;
    logic [31:0] load_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy   <= 1'b0;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (mem_start) begin
                busy <= 1'b1;
            end else if (busy && !bus_rsp.waitrequest) begin
                busy   <= 1'b0;
                done_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mem_start) begin
            write_q <= mem_write;
            addr_q  <= mem_addr;
            data_q  <= store_data;
        end
        if (done_q && !write_q) load_q <= bus_rsp.readdata; // keep the word for WB.
    end

    assign mem_done  = done_q;
    assign load_data = done_q ? bus_rsp.readdata : load_q;

    always_comb begin
        bus_req.address   = addr_q;
        bus_req.read      = busy && !write_q;
        bus_req.write     = busy && write_q;
        bus_req.writedata = data_q;
    end

endmodule

//--- src/mips_core.sv
`timescale 1ns/100ps

module mips_core import mips_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        run,
    output logic        active,
    output logic [31:0] register_v0,
    output logic        start_fetch,
    input  logic        fetch_done,
    input  instr_t      instr,
    output logic        pc_load,
    output logic [31:0] new_pc,
    output logic        mem_start,
    output logic        mem_write,
    output logic [31:0] mem_addr,
    output logic [31:0] store_data,
    input  logic        mem_done,
    input  logic [31:0] load_data
);

    core_state_t state_q;
    logic [31:0] regs [32];
    logic [31:0] rs_val;
    logic [31:0] rt_val;
    logic [31:0] imm_sext;
    logic [31:0] alu_res;
    logic [4:0]  dest;
    logic        wb_en;
    logic        is_mem;
    logic        is_store;
    logic        is_jr;
    logic [31:0] result_q;
    logic [4:0]  dest_q;
    logic        wb_en_q;
    logic        load_q;

    // register 0 reads as zero whatever the array holds.
    assign rs_val   = (instr.r_view.rs == 5'd0) ? 32'd0 : regs[instr.r_view.rs];
    assign rt_val   = (instr.r_view.rt == 5'd0) ? 32'd0 : regs[instr.r_view.rt];
    assign imm_sext = {{16{instr.i_view.imm[15]}}, instr.i_view.imm};

    always_comb begin
        alu_res  = rs_val + imm_sext; // also the load/store address.
        dest     = instr.i_view.rt;
        wb_en    = 1'b0;
        is_mem   = 1'b0;
        is_store = 1'b0;
        is_jr    = 1'b0;
        case (instr.r_view.opcode)
            op_addiu: wb_en = 1'b1;
            op_lw: begin
                wb_en  = 1'b1;
                is_mem = 1'b1;
            end
            op_sw: begin
                is_mem   = 1'b1;
                is_store = 1'b1;
            end
            op_special: begin
                dest  = instr.r_view.rd;
                wb_en = 1'b1;
                case (instr.r_view.funct)
                    fn_addu: alu_res = rs_val + rt_val;
                    fn_subu: alu_res = rs_val - rt_val;
                    fn_sllv: alu_res = rt_val << rs_val[4:0];
                    fn_srlv: alu_res = rt_val >> rs_val[4:0];
                    fn_srav: alu_res = $signed(rt_val) >>> rs_val[4:0];
                    fn_jr: begin
                        wb_en = 1'b0;
                        is_jr = 1'b1;
                    end
                    default: wb_en = 1'b0;
                endcase
            end
            default: ; // anything else passes through as a no-op.
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q     <= IDLE;
            start_fetch <= 1'b0;
            pc_load     <= 1'b0;
            mem_start   <= 1'b0;
        end else begin
            start_fetch <= 1'b0;
            pc_load     <= 1'b0;
            mem_start   <= 1'b0;
            case (state_q)
                IDLE: if (run) begin
                    state_q     <= FETCH;
                    start_fetch <= 1'b1;
                end
                FETCH: if (fetch_done) state_q <= EXEC;
                EXEC: begin
                    if (is_jr && rs_val == 32'd0) begin
                        state_q <= HALT; // a jump to zero ends the program.
                    end else if (is_mem) begin
                        state_q   <= MEM;
                        mem_start <= 1'b1;
                    end else begin
                        state_q <= WB;
                        pc_load <= is_jr;
                    end
                end
                MEM: if (mem_done) state_q <= WB;
                WB: begin
                    state_q     <= FETCH;
                    start_fetch <= 1'b1;
                end
                HALT: state_q <= HALT;
                default: state_q <= IDLE;
            endcase
        end
    end

    // operands and results captured in EXEC for the later stages.
    always_ff @(posedge clk) begin
        if (state_q == EXEC) begin
            result_q   <= alu_res;
            dest_q     <= dest;
            wb_en_q    <= wb_en;
            load_q     <= is_mem && !is_store;
            new_pc     <= rs_val;
            mem_write  <= is_store;
            mem_addr   <= alu_res;
            store_data <= rt_val;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == WB && wb_en_q && dest_q != 5'd0) begin
            regs[dest_q] <= load_q ? load_data : result_q;
        end
    end

    assign active      = (state_q != IDLE) && (state_q != HALT);
    assign register_v0 = regs[2];

endmodule

//--- src/avalon_ram.sv
`timescale 1ns/100ps

module avalon_ram import mips_pkg::*; #(
    parameter int WAIT_CYCLES = 1
) (
    input  logic        clk,
    input  logic        arst_n,
    input  bus_req_t    bus_req,
    output bus_rsp_t    bus_rsp,
    input  logic        prog_we,
    input  logic [7:0]  prog_addr,
    input  logic [31:0] prog_data
);

    localparam int CNT_W = (WAIT_CYCLES > 1) ? $clog2(WAIT_CYCLES + 1) : 1;

    logic [31:0]      mem [256];
    logic [CNT_W-1:0] wait_cnt;
    logic [31:0]      rdata_q;
    logic [7:0]       idx;
    logic             strobe;
    logic             stall;
    logic             done;

    assign idx    = bus_req.address[9:2]; // word index of the byte address.
    assign strobe = bus_req.read | bus_req.write;
    assign stall  = strobe && (int'(wait_cnt) < WAIT_CYCLES);
    assign done   = strobe && !stall;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wait_cnt <= '0;
        end else if (done || !strobe) begin
            wait_cnt <= '0;
        end else begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    // the program port takes priority over a bus write to the same array.
    always_ff @(posedge clk) begin
        if (done && bus_req.read) rdata_q <= mem[idx];
        if (prog_we) begin
            mem[prog_addr] <= prog_data;
        end else if (done && bus_req.write) begin
            mem[idx] <= bus_req.writedata;
        end
    end

    always_comb begin
        bus_rsp.waitrequest = stall;
        bus_rsp.readdata    = rdata_q;
    end

endmodule

//--- src/mips_cpu_top.sv
`timescale 1ns/100ps

module mips_cpu_top import mips_pkg::*; #(
    parameter logic [31:0] RESET_PC    = 32'd4,
    parameter int          WAIT_CYCLES = 1
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        run,
    input  logic        prog_we,
    input  logic [7:0]  prog_addr,
    input  logic [31:0] prog_data,
    output logic        active,
    output logic [31:0] register_v0
);

    logic        start_fetch;
    logic        fetch_done;
    instr_t      instr;
    logic        pc_load;
    logic [31:0] new_pc;
    logic        mem_start;
    logic        mem_write;
    logic [31:0] mem_addr;
    logic [31:0] store_data;
    logic        mem_done;
    logic [31:0] load_data;
    bus_req_t    ifu_req;
    bus_rsp_t    ifu_rsp;
    bus_req_t    lsu_req;
    bus_rsp_t    lsu_rsp;
    bus_req_t    mem_req;
    bus_rsp_t    mem_rsp;

    mips_core core (
        .clk, .arst_n, .run, .active, .register_v0,
        .start_fetch, .fetch_done, .instr, .pc_load, .new_pc,
        .mem_start, .mem_write, .mem_addr, .store_data, .mem_done, .load_data
    );

    instr_fetch #(.RESET_PC(RESET_PC)) ifu (
        .clk, .arst_n, .start_fetch, .pc_load, .new_pc, .fetch_done, .instr,
        .pc(), .bus_req(ifu_req), .bus_rsp(ifu_rsp)
    );

    load_store_unit lsu (
        .clk, .arst_n, .mem_start, .mem_write, .mem_addr, .store_data,
        .mem_done, .load_data, .bus_req(lsu_req), .bus_rsp(lsu_rsp)
    );

    bus_arbiter arb (
        .clk, .arst_n, .lsu_req, .lsu_rsp, .ifu_req, .ifu_rsp, .mem_req, .mem_rsp
    );

    avalon_ram #(.WAIT_CYCLES(WAIT_CYCLES)) ram (
        .clk, .arst_n, .bus_req(mem_req), .bus_rsp(mem_rsp),
        .prog_we, .prog_addr, .prog_data
    );

endmodule

//--- bench/mips_cpu_tb.sv
`timescale 1ns/100ps

module mips_cpu_tb import mips_pkg::*; ();

    localparam int WAIT_CYCLES = 2;
    localparam int NUM_PROGS   = 12; // reference, zero register, 6 ALU, 4 store/load.
    localparam int CYCLE_LIMIT = NUM_PROGS * 64 * (WAIT_CYCLES + 6);

    logic        clk;
    logic        arst_n;
    logic        run;
    logic        prog_we;
    logic [7:0]  prog_addr;
    logic [31:0] prog_data;
    logic        active;
    logic [31:0] register_v0;

    logic [31:0] rng;
    logic [31:0] prog [$];        // program words, placed from word 1 (pc 4) on.
    logic [31:0] model_mem [256];
    logic [31:0] model_regs [32];
    int          cycles = 0;

    mips_cpu_top #(.RESET_PC(32'd4), .WAIT_CYCLES(WAIT_CYCLES)) uut (
        .clk, .arst_n, .run, .prog_we, .prog_addr, .prog_data, .active, .register_v0
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1, "run stopped at the first error");
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT)
            fail_run($sformatf("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT));
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    task automatic next_rand(output logic [31:0] r);
        rng = xorshift(rng);
        r   = rng;
    endtask

    function automatic logic [31:0] rtype_word(input logic [4:0] rs, input logic [4:0] rt,
                                               input logic [4:0] rd, input logic [5:0] fn);
        return {op_special, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] itype_word(input logic [5:0] op, input logic [4:0] rs,
                                               input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // executes the program in model_mem from pc 4 and returns the predicted v0.
    task automatic predict_v0(output logic [31:0] v0);
        logic [31:0] pc;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sext;
        logic [31:0] addr;
        logic        halted;
        int          steps;
        pc     = 32'd4;
        halted = 1'b0;
        steps  = 0;
        while (!halted && steps < 64) begin
            w    = model_mem[pc[9:2]];
            a    = model_regs[w[25:21]];
            b    = model_regs[w[20:16]];
            sext = {{16{w[15]}}, w[15:0]};
            addr = a + sext;
            pc   = pc + 32'd4;
            if (w[31:26] == op_addiu) model_regs[w[20:16]] = addr;
            else if (w[31:26] == op_lw) model_regs[w[20:16]] = model_mem[addr[9:2]];
            else if (w[31:26] == op_sw) model_mem[addr[9:2]] = b;
            else if (w[31:26] == op_special) begin
                case (w[5:0])
                    fn_addu: model_regs[w[15:11]] = a + b;
                    fn_subu: model_regs[w[15:11]] = a - b;
                    fn_sllv: model_regs[w[15:11]] = b << a[4:0];
                    fn_srlv: model_regs[w[15:11]] = b >> a[4:0];
                    // logical shift, then the vacated top bits filled with the sign.
                    fn_srav: model_regs[w[15:11]] = (b >> a[4:0]) |
                                                    (b[31] ? ~(32'hFFFF_FFFF >> a[4:0]) : 32'd0);
                    fn_jr: begin
                        if (a == 32'd0) halted = 1'b1;
                        else pc = a;
                    end
                    default: ;
                endcase
            end
            model_regs[0] = 32'd0;
            steps++;
        end
        if (!halted) fail_run("The reference model ran 64 instructions without reaching JR zero.");
        v0 = model_regs[2];
    endtask

    // holds reset for at least 16 cycles and writes the program meanwhile.
    task automatic load_program();
        int n;
        int len;
        n   = prog.size();
        len = (n > 16) ? n : 16;
        @(posedge clk);
        arst_n <= 1'b0;
        run    <= 1'b0;
        for (int i = 0; i < len; i++) begin
            @(posedge clk);
            prog_we <= (i < n);
            if (i < n) begin
                prog_addr       <= 8'(i + 1);
                prog_data       <= prog[i];
                model_mem[i + 1] = prog[i];
            end
            @(negedge clk);
            assert (!active)
                else fail_run($sformatf("Mismatch at %0t: active is high in reset", $time));
        end
        @(posedge clk);
        prog_we <= 1'b0;
        arst_n  <= 1'b1;
    endtask

    task automatic run_and_check(input string name, input logic [31:0] expect_v0);
        repeat (2) begin
            @(negedge clk);
            assert (!active)
                else fail_run($sformatf("Mismatch at %0t: %s, active high before run", $time, name));
        end
        @(posedge clk);
        run <= 1'b1;
        @(negedge clk);
        while (!active) @(negedge clk);
        while (active) @(negedge clk);
        // run stays high here, so a second start would show up as active again.
        repeat (8) begin
            @(negedge clk);
            assert (!active)
                else fail_run($sformatf("Mismatch at %0t: %s, active rose after halt", $time, name));
        end
        assert (register_v0 === expect_v0)
            else fail_run($sformatf("Mismatch at %0t: %s, v0 is %h, expected %h",
                                    $time, name, register_v0, expect_v0));
        @(posedge clk);
        run <= 1'b0;
    endtask

    task automatic execute_program(input string name, output logic [31:0] expect_v0);
        load_program();
        predict_v0(expect_v0);
        run_and_check(name, expect_v0);
    endtask

    task automatic random_alu_program();
        logic [31:0] x;
        int          ops;
        prog.delete();
        for (int r = 2; r < 8; r++) begin
            next_rand(x);
            prog.push_back(itype_word(op_addiu, 5'd0, 5'(r), x[15:0]));
        end
        next_rand(x);
        ops = 6 + int'(x[3:0]) % 11;
        for (int k = 0; k < ops; k++) begin
            next_rand(x);
            case (int'(x[7:0]) % 6)
                0: prog.push_back(rtype_word(5'(2 + int'(x[12:8]) % 6), 5'(2 + int'(x[17:13]) % 6),
                                             5'(2 + int'(x[22:18]) % 6), fn_addu));
                1: prog.push_back(rtype_word(5'(2 + int'(x[12:8]) % 6), 5'(2 + int'(x[17:13]) % 6),
                                             5'(2 + int'(x[22:18]) % 6), fn_subu));
                2: prog.push_back(rtype_word(5'(2 + int'(x[12:8]) % 6), 5'(2 + int'(x[17:13]) % 6),
                                             5'(2 + int'(x[22:18]) % 6), fn_sllv));
                3: prog.push_back(rtype_word(5'(2 + int'(x[12:8]) % 6), 5'(2 + int'(x[17:13]) % 6),
                                             5'(2 + int'(x[22:18]) % 6), fn_srlv));
                4: prog.push_back(rtype_word(5'(2 + int'(x[12:8]) % 6), 5'(2 + int'(x[17:13]) % 6),
                                             5'(2 + int'(x[22:18]) % 6), fn_srav));
                default: prog.push_back(itype_word(op_addiu, 5'(2 + int'(x[12:8]) % 6),
                                                   5'(2 + int'(x[17:13]) % 6), x[31:16]));
            endcase
        end
        next_rand(x);
        prog.push_back(rtype_word(5'(2 + int'(x[4:0]) % 6), 5'd0, 5'd2, fn_addu));
        prog.push_back(rtype_word(5'd0, 5'd0, 5'd0, fn_jr));
    endtask

    // data lives in words 128 to 255, well above any program.
    task automatic store_load_program();
        logic [31:0] x;
        logic [31:0] y;
        prog.delete();
        next_rand(x);
        next_rand(y);
        prog.push_back(itype_word(op_addiu, 5'd0, 5'd8, 16'h0200));
        prog.push_back(itype_word(op_addiu, 5'd0, 5'd10, {11'd0, x[4:0]}));
        prog.push_back(itype_word(op_addiu, 5'd0, 5'd9, x[31:16]));
        prog.push_back(rtype_word(5'd10, 5'd9, 5'd9, fn_sllv));
        prog.push_back(itype_word(op_sw, 5'd8, 5'd9, {7'd0, x[13:7], 2'b00}));
        prog.push_back(itype_word(op_addiu, 5'd0, 5'd12, y[31:16]));
        prog.push_back(itype_word(op_sw, 5'd8, 5'd12, {7'd0, y[6:0], 2'b00}));
        prog.push_back(itype_word(op_lw, 5'd8, 5'd2, {7'd0, x[13:7], 2'b00}));
        prog.push_back(rtype_word(5'd0, 5'd0, 5'd0, fn_jr));
    endtask

    initial begin
        logic [31:0] expect_v0;
        logic [31:0] x;
        arst_n    <= 1'b0;
        run       <= 1'b0;
        prog_we   <= 1'b0;
        prog_addr <= 8'd0;
        prog_data <= 32'd0;
        rng = 32'd97675;
        for (int i = 0; i < 256; i++) model_mem[i] = 32'd0;
        for (int i = 0; i < 32; i++) model_regs[i] = 32'd0;

        prog.delete();
        prog.push_back(itype_word(op_addiu, 5'd0, 5'd2, 16'hA234));
        prog.push_back(itype_word(op_addiu, 5'd0, 5'd3, 16'd8));
        prog.push_back(rtype_word(5'd3, 5'd2, 5'd2, fn_srav));
        prog.push_back(rtype_word(5'd0, 5'd0, 5'd0, fn_jr));
        execute_program("reference SRAV case", expect_v0);
        assert (expect_v0 == 32'hFFFF_FFA2)
            else fail_run($sformatf("Mismatch at %0t: model SRAV gave %h", $time, expect_v0));

        next_rand(x);
        prog.delete();
        prog.push_back(itype_word(op_addiu, 5'd0, 5'd0, x[15:0] | 16'h0001)); // never zero.
        prog.push_back(rtype_word(5'd0, 5'd0, 5'd2, fn_addu));
        prog.push_back(rtype_word(5'd0, 5'd0, 5'd0, fn_jr));
        execute_program("register zero write", expect_v0);

        for (int p = 0; p < 6; p++) begin
            random_alu_program();
            execute_program($sformatf("random ALU program %0d", p), expect_v0);
        end
        for (int p = 0; p < 4; p++) begin
            store_load_program();
            execute_program($sformatf("store/load program %0d", p), expect_v0);
        end

        $display("All tests passed");
        $finish;
    end

endmodule

//--- mips_cpu_top.f
src/mips_pkg.sv
src/bus_arbiter.sv
src/instr_fetch.sv
src/load_store_unit.sv
src/mips_core.sv
src/avalon_ram.sv
src/mips_cpu_top.sv
bench/mips_cpu_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module mips_cpu_tb \
    -f mips_cpu_top.f --Mdir obj_dir -o mips_cpu_sim

./obj_dir/mips_cpu_sim 2>&1 | tee sim.log

if grep -q "All tests passed" sim.log; then
    echo "simulation result: PASS"
else
    echo "simulation result: FAIL"
    exit 1
fi
